//--- include/cgra_macros.svh
`ifndef CGRA_MACROS_SVH
`define CGRA_MACROS_SVH

// host bus widths
`define CGRA_ADDR_W      8
`define CGRA_DATA_W      16

// array geometry
`define CGRA_N_STAGE     4
`define CGRA_STAGE_W     2
`define CGRA_MEM_ADDR_W  4

// host address fields
`define CGRA_IDX_MSB     3
`define CGRA_IDX_LSB     0
`define CGRA_STG_MSB     5
`define CGRA_STG_LSB     4
`define CGRA_REG_MSB     7
`define CGRA_REG_LSB     6
`define CGRA_REGION_W    2

// config index that clears every stage's record at once
`define CGRA_CONF_CLEAR  15

// config field widths
`define CGRA_OP_W        3
`define CGRA_LEN_W       5

`endif

//--- src/cgra_addr_pkg.sv
`default_nettype none

`include "cgra_macros.svh"

package cgra_addr_pkg;

   // top two address bits
   typedef enum logic [`CGRA_REGION_W-1:0] {
      REG_MEM  = 2'd0,
      REG_CTRL = 2'd1,
      REG_CONF = 2'd2,
      REG_NONE = 2'd3
   } region_t;

   // one host access after field decode
   typedef struct packed {
      region_t                     region;
      logic [`CGRA_STAGE_W-1:0]    stage;
      logic [`CGRA_MEM_ADDR_W-1:0] index;
      logic                        we;
      logic [`CGRA_DATA_W-1:0]     wdata;
   } host_access_t;

endpackage

`default_nettype wire

//--- src/cgra_fu_pkg.sv
`default_nettype none

`include "cgra_macros.svh"

package cgra_fu_pkg;

   typedef enum logic [`CGRA_OP_W-1:0] {
      OP_ADD       = 3'd0,
      OP_SUB       = 3'd1,
      OP_AND       = 3'd2,
      OP_XOR       = 3'd3,
      OP_PASS_OWN  = 3'd4,
      OP_PASS_RING = 3'd5
   } fu_op_t;

   // per-stage run settings, all zero after reset or clear
   typedef struct packed {
      fu_op_t                      op;
      logic [`CGRA_MEM_ADDR_W-1:0] src;
      logic [`CGRA_MEM_ADDR_W-1:0] dst;
      logic [`CGRA_LEN_W-1:0]      len;
   } stage_conf_t;

   // config register indexes
   localparam logic [`CGRA_MEM_ADDR_W-1:0] CONF_IDX_OP  = 4'd0;
   localparam logic [`CGRA_MEM_ADDR_W-1:0] CONF_IDX_SRC = 4'd1;
   localparam logic [`CGRA_MEM_ADDR_W-1:0] CONF_IDX_DST = 4'd2;
   localparam logic [`CGRA_MEM_ADDR_W-1:0] CONF_IDX_LEN = 4'd3;

endpackage

`default_nettype wire

//--- src/cgra_ctrl_if.sv
`default_nettype none

`include "cgra_macros.svh"

// host control path into a single stage
interface cgra_ctrl_if
   import cgra_addr_pkg::*;
();

   // one-cycle strobe per access
   logic                        sel;
   logic                        we;
   region_t                     region;
   logic [`CGRA_MEM_ADDR_W-1:0] index;
   logic [`CGRA_DATA_W-1:0]     wr_data;
   // registered, valid the cycle after sel
   logic [`CGRA_DATA_W-1:0]     rd_data;

   modport master (output sel, we, region, index, wr_data, input rd_data);

   modport slave (input sel, we, region, index, wr_data, output rd_data);

endinterface

`default_nettype wire

//--- src/cgra_addr_decoder.sv
`default_nettype none

`include "cgra_macros.svh"

module cgra_addr_decoder
   import cgra_addr_pkg::*;
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        valid,
   input  wire [`CGRA_ADDR_W-1:0]     addr,
   input  wire                        we,
   input  wire [`CGRA_DATA_W-1:0]     rdata,
   output logic                       ready,
   output logic [`CGRA_DATA_W-1:0]    wdata,
   input  wire [`CGRA_N_STAGE-1:0]    done_vec,
   cgra_ctrl_if.master                ctrl [`CGRA_N_STAGE]
);

   host_access_t            cur;
   logic                    valid_q;
   logic                    first;
   logic                    mem_q;
   logic                    is_run;
   logic                    is_clear;
   logic [`CGRA_N_STAGE-1:0] sel;
   logic [`CGRA_DATA_W-1:0] rd_vec [`CGRA_N_STAGE];

   // addr and data are held by the host until ready
   always_comb begin
      cur.region = region_t'(addr[`CGRA_REG_MSB:`CGRA_REG_LSB]);
      cur.stage  = addr[`CGRA_STG_MSB:`CGRA_STG_LSB];
      cur.index  = addr[`CGRA_IDX_MSB:`CGRA_IDX_LSB];
      cur.we     = we;
      cur.wdata  = rdata;
   end

   assign first    = valid & ~valid_q;
   assign is_run   = cur.we & (cur.region == REG_CTRL);
   assign is_clear = cur.we & (cur.region == REG_CONF) & (cur.index == `CGRA_CONF_CLEAR);

   // run and clear go to every stage, the rest only to the addressed one
   always_comb begin
      for (int j = 0; j < `CGRA_N_STAGE; j++) begin
         sel[j] = 1'b0;
         if (is_run || is_clear)
            sel[j] = first;
         else if ((cur.region == REG_MEM || cur.region == REG_CONF) &&
                  cur.stage == `CGRA_STAGE_W'(j))
            sel[j] = first;
      end
   end

   for (genvar g = 0; g < `CGRA_N_STAGE; g++) begin : g_ctrl
      assign ctrl[g].sel     = sel[g];
      assign ctrl[g].we      = cur.we;
      assign ctrl[g].region  = cur.region;
      assign ctrl[g].index   = cur.index;
      assign ctrl[g].wr_data = cur.wdata;
      assign rd_vec[g]       = ctrl[g].rd_data;
   end

   // memory needs an extra cycle for the registered read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
         mem_q   <= 1'b0;
         ready   <= 1'b0;
      end else begin
         valid_q <= valid;
         mem_q   <= first & (cur.region == REG_MEM);
         ready   <= mem_q | (first & (cur.region != REG_MEM));
      end
   end

   always_comb begin
      case (cur.region)
         REG_MEM:  wdata = rd_vec[cur.stage];
         REG_CTRL: wdata = {{(`CGRA_DATA_W-1){1'b0}}, &done_vec};
         default:  wdata = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/cgra_conf_bank.sv
`default_nettype none

`include "cgra_macros.svh"

module cgra_conf_bank
   import cgra_addr_pkg::*;
   import cgra_fu_pkg::*;
(
   input  wire         clk,
   input  wire         rst,
   cgra_ctrl_if.slave  ctrl,
   output stage_conf_t conf
);

   logic conf_wr;

   assign conf_wr = ctrl.sel & ctrl.we & (ctrl.region == REG_CONF);

   // one field per index, upper data bits ignored
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         conf <= '0;
      end else if (conf_wr) begin
         case (ctrl.index)
            CONF_IDX_OP: begin
               conf.op <= fu_op_t'(ctrl.wr_data[`CGRA_OP_W-1:0]);
            end
            CONF_IDX_SRC: begin
               conf.src <= ctrl.wr_data[`CGRA_MEM_ADDR_W-1:0];
            end
            CONF_IDX_DST: begin
               conf.dst <= ctrl.wr_data[`CGRA_MEM_ADDR_W-1:0];
            end
            CONF_IDX_LEN: begin
               conf.len <= ctrl.wr_data[`CGRA_LEN_W-1:0];
            end
            `CGRA_MEM_ADDR_W'(`CGRA_CONF_CLEAR): begin
               // back to OP_ADD with an empty window
               conf <= '0;
            end
            default: begin
               conf <= conf;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/cgra_stage.sv
`default_nettype none

`include "cgra_macros.svh"

module cgra_stage
   import cgra_addr_pkg::*;
   import cgra_fu_pkg::*;
(
   input  wire                     clk,
   input  wire                     rst,
   cgra_ctrl_if.slave              ctrl,
   input  wire [`CGRA_DATA_W-1:0]  ring_in,
   output logic [`CGRA_DATA_W-1:0] ring_out,
   output logic                    done
);

   localparam int unsigned N_WORDS = 1 << `CGRA_MEM_ADDR_W;

   stage_conf_t                 conf;
   logic [`CGRA_DATA_W-1:0]     mem [N_WORDS];
   logic [`CGRA_DATA_W-1:0]     result;
   logic [`CGRA_LEN_W-1:0]      rd_cnt;
   logic                        rd_active;
   logic                        wb_valid;
   logic [`CGRA_MEM_ADDR_W-1:0] rd_addr;
   logic [`CGRA_MEM_ADDR_W-1:0] wb_addr;
   logic                        run_cmd;
   logic                        host_wr;
   logic                        host_rd;

   cgra_conf_bank conf_bank_i (
      .clk  (clk),
      .rst  (rst),
      .ctrl (ctrl),
      .conf (conf)
   );

   assign run_cmd = ctrl.sel & ctrl.we & (ctrl.region == REG_CTRL);
   // host memory writes only land while idle
   assign host_wr = ctrl.sel & ctrl.we & (ctrl.region == REG_MEM) & done;
   assign host_rd = ctrl.sel & ~ctrl.we & (ctrl.region == REG_MEM);
   assign rd_addr = conf.src + rd_cnt[`CGRA_MEM_ADDR_W-1:0];

   // run sequencing, read step then compute/write step
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_active <= 1'b0;
         rd_cnt    <= '0;
         wb_valid  <= 1'b0;
         done      <= 1'b1;
      end else begin
         wb_valid <= rd_active;
         if (run_cmd) begin
            rd_active <= (conf.len != '0);
            rd_cnt    <= '0;
            done      <= (conf.len == '0);
         end else begin
            if (rd_active) begin
               rd_cnt <= rd_cnt + 1'b1;
               if (rd_cnt == conf.len - 1'b1)
                  rd_active <= 1'b0;
            end
            // last write goes out the cycle reads have stopped
            if (wb_valid && !rd_active)
               done <= 1'b1;
         end
      end
   end

   // ring_out doubles as the own operand of the next step
   always_comb begin
      case (conf.op)
         OP_ADD:       result = ring_out + ring_in;
         OP_SUB:       result = ring_out - ring_in;
         OP_AND:       result = ring_out & ring_in;
         OP_XOR:       result = ring_out ^ ring_in;
         OP_PASS_RING: result = ring_in;
         default:      result = ring_out;
      endcase
   end

   always_ff @(posedge clk) begin
      if (wb_valid)
         mem[wb_addr] <= result;
      else if (host_wr)
         mem[ctrl.index] <= ctrl.wr_data;
      if (rd_active) begin
         ring_out <= mem[rd_addr];
         wb_addr  <= conf.dst + rd_cnt[`CGRA_MEM_ADDR_W-1:0];
      end
      if (host_rd)
         ctrl.rd_data <= mem[ctrl.index];
   end

endmodule

`default_nettype wire

//--- src/cgra_top.sv
`default_nettype none

`include "cgra_macros.svh"

module cgra_top (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     valid,
   input  wire [`CGRA_ADDR_W-1:0]  addr,
   input  wire                     we,
   input  wire [`CGRA_DATA_W-1:0]  rdata,
   output logic                    ready,
   output logic [`CGRA_DATA_W-1:0] wdata
);

   wire [`CGRA_N_STAGE-1:0] done_vec;
   wire [`CGRA_DATA_W-1:0]  ring [`CGRA_N_STAGE];

   cgra_ctrl_if ctrl_bus [`CGRA_N_STAGE] ();

   cgra_addr_decoder decoder_i (
      .clk      (clk),
      .rst      (rst),
      .valid    (valid),
      .addr     (addr),
      .we       (we),
      .rdata    (rdata),
      .ready    (ready),
      .wdata    (wdata),
      .done_vec (done_vec),
      .ctrl     (ctrl_bus)
   );

   // stage k takes the word read by stage k-1, stage 0 closes the ring
   for (genvar k = 0; k < `CGRA_N_STAGE; k++) begin : g_stage
      cgra_stage stage_i (
         .clk      (clk),
         .rst      (rst),
         .ctrl     (ctrl_bus[k]),
         .ring_in  (ring[(k + `CGRA_N_STAGE - 1) % `CGRA_N_STAGE]),
         .ring_out (ring[k]),
         .done     (done_vec[k])
      );
   end

endmodule

`default_nettype wire

//--- verif/cgra_clkgen.sv
`default_nettype none

module cgra_clkgen (
   output logic clk,
   output logic rst
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // reset held for three rising edges
   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

//--- verif/cgra_checker.sv
`default_nettype none

`include "cgra_macros.svh"

module cgra_checker
   import cgra_addr_pkg::*;
(
   input wire                    clk,
   input wire                    rst,
   input wire                    valid,
   input wire                    ready,
   input wire                    we,
   input wire [`CGRA_ADDR_W-1:0] addr,
   input wire [`CGRA_DATA_W-1:0] wdata
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_cnt = 0;

   // one ready pulse per access
   ready_single: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
      else begin
         fail_cnt++;
         $error("ready stayed high for two cycles");
      end

   ready_cause: assert property (@(posedge clk) disable iff (rst)
      $rose(ready) |-> ($past(valid) || $past(valid, 2)))
      else begin
         fail_cnt++;
         $error("ready rose without a preceding valid");
      end

   // done flag is the only live bit of a control read
   ctrl_read_bits: assert property (@(posedge clk) disable iff (rst)
      (ready && !we && region_t'(addr[`CGRA_REG_MSB:`CGRA_REG_LSB]) == REG_CTRL)
      |-> (wdata[`CGRA_DATA_W-1:1] == '0))
      else begin
         fail_cnt++;
         $error("control read returned bits above bit 0");
      end

endmodule

bind cgra_addr_decoder cgra_checker checker_i (
   .clk   (clk),
   .rst   (rst),
   .valid (valid),
   .ready (ready),
   .we    (we),
   .addr  (addr),
   .wdata (wdata)
);

`default_nettype wire

//--- verif/cgra_tb.sv
`default_nettype none

`include "cgra_macros.svh"

module cgra_tb
   import cgra_addr_pkg::*;
   import cgra_fu_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_ROWS = 7;
   localparam int N_WORDS = 1 << `CGRA_MEM_ADDR_W;
   localparam int READY_TIMEOUT = 20;
   localparam int DONE_POLLS = 40;

   typedef struct {
      fu_op_t                  op;
      int                      len;
      int                      src;
      int                      dst;
      logic [`CGRA_DATA_W-1:0] base;
   } test_row_t;

   logic                    clk;
   logic                    rst;
   logic                    valid;
   logic [`CGRA_ADDR_W-1:0] addr;
   logic                    we;
   logic [`CGRA_DATA_W-1:0] rdata;
   logic                    ready;
   logic [`CGRA_DATA_W-1:0] wdata;
   test_row_t               rows [N_ROWS];
   logic [`CGRA_DATA_W-1:0] model [`CGRA_N_STAGE][N_WORDS];
   integer                  seed;
   int                      checks;
   int                      errors;

   cgra_clkgen clkgen_i (.clk(clk), .rst(rst));

   cgra_top cgra_top_i (
      .clk(clk), .rst(rst), .valid(valid), .addr(addr),
      .we(we), .rdata(rdata), .ready(ready), .wdata(wdata)
   );

   function automatic logic [`CGRA_ADDR_W-1:0] make_addr(region_t r, int stage, int index);
      return {r, stage[`CGRA_STAGE_W-1:0], index[`CGRA_MEM_ADDR_W-1:0]};
   endfunction

   // own word first, ring word second
   function automatic logic [`CGRA_DATA_W-1:0] expected_result(fu_op_t op,
         logic [`CGRA_DATA_W-1:0] own, logic [`CGRA_DATA_W-1:0] ring);
      case (op)
         OP_ADD:       return own + ring;
         OP_SUB:       return own - ring;
         OP_AND:       return own & ring;
         OP_XOR:       return own ^ ring;
         OP_PASS_RING: return ring;
         default:      return own;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [`CGRA_DATA_W-1:0] exp,
         input logic [`CGRA_DATA_W-1:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, got);
      end
   endtask

   // entered and left on a rising edge; mem region acks after 2 cycles, others after 1
   task automatic host_access(input string name, input logic [`CGRA_ADDR_W-1:0] a,
         input logic w, input logic [`CGRA_DATA_W-1:0] d,
         output logic [`CGRA_DATA_W-1:0] rd);
      int cycles;
      logic seen;
      cycles = 0;
      seen = 1'b0;
      valid <= 1'b1;
      addr <= a;
      we <= w;
      rdata <= d;
      while (!seen && cycles < READY_TIMEOUT) begin
         @(posedge clk);
         cycles++;
         seen = ready;
      end
      rd = wdata;
      valid <= 1'b0;
      we <= 1'b0;
      @(posedge clk);
      assert (seen) else begin
         errors++;
         $display("%s: no ready within %0d cycles", name, READY_TIMEOUT);
      end
      if (seen)
         check_value({name, " latency"}, (a[7:6] == REG_MEM) ? 2 : 1, cycles - 1);
   endtask

   task automatic host_write(input string name, input logic [`CGRA_ADDR_W-1:0] a,
         input logic [`CGRA_DATA_W-1:0] d);
      logic [`CGRA_DATA_W-1:0] discard;
      host_access(name, a, 1'b1, d, discard);
   endtask

   task automatic fill_memories(input logic [`CGRA_DATA_W-1:0] base);
      logic [`CGRA_DATA_W-1:0] word;
      for (int s = 0; s < `CGRA_N_STAGE; s++) begin
         for (int w = 0; w < N_WORDS; w++) begin
            word = base + 16'(17 * s) + 16'(w);
            model[s][w] = word;
            host_write($sformatf("fill s%0d w%0d", s, w), make_addr(REG_MEM, s, w), word);
         end
      end
   endtask

   task automatic verify_memories(input string name);
      logic [`CGRA_DATA_W-1:0] rd;
      for (int s = 0; s < `CGRA_N_STAGE; s++) begin
         for (int w = 0; w < N_WORDS; w++) begin
            host_access($sformatf("%s s%0d w%0d", name, s, w), make_addr(REG_MEM, s, w),
                        1'b0, '0, rd);
            check_value($sformatf("%s s%0d w%0d", name, s, w), model[s][w], rd);
         end
      end
   endtask

   // ring predecessor of stage k is k-1, stage 0 takes stage 3
   task automatic apply_row_to_model(input test_row_t row);
      logic [`CGRA_DATA_W-1:0] orig [`CGRA_N_STAGE][N_WORDS];
      int si;
      int di;
      orig = model;
      for (int k = 0; k < `CGRA_N_STAGE; k++) begin
         for (int i = 0; i < row.len; i++) begin
            si = (row.src + i) % N_WORDS;
            di = (row.dst + i) % N_WORDS;
            model[k][di] = expected_result(row.op, orig[k][si],
                                           orig[(k + `CGRA_N_STAGE - 1) % `CGRA_N_STAGE][si]);
         end
      end
   endtask

   task automatic run_and_wait(input string name, input int max_polls);
      logic [`CGRA_DATA_W-1:0] rd;
      int polls;
      polls = 0;
      rd = '0;
      host_write({name, " run"}, make_addr(REG_CTRL, 0, 0), 16'h1);
      while (!rd[0] && polls < max_polls) begin
         host_access({name, " poll"}, make_addr(REG_CTRL, 0, 0), 1'b0, '0, rd);
         polls++;
      end
      assert (rd[0]) else begin
         errors++;
         $display("%s: done flag still low after %0d polls", name, polls);
      end
   endtask

   initial begin
      logic [`CGRA_DATA_W-1:0] rd;
      int cycles;
      int total;
      seed = 32'h4c2;
      checks = 0;
      errors = 0;
      valid = 1'b0;
      addr = '0;
      we = 1'b0;
      rdata = '0;
      // op, len, src, dst, base; windows either disjoint or in place
      rows[0] = '{OP_ADD, 4, 0, 8, 16'h0};
      rows[1] = '{OP_SUB, 5, 2, 10, 16'h0};
      rows[2] = '{OP_AND, 3, 12, 1, 16'h0};
      rows[3] = '{OP_XOR, 6, 4, 4, 16'h0};
      rows[4] = '{OP_PASS_OWN, 2, 9, 13, 16'h0};
      rows[5] = '{OP_PASS_RING, 16, 3, 3, 16'h0};
      rows[6] = '{OP_SUB, 8, 8, 0, 16'h0};
      for (int r = 0; r < N_ROWS; r++)
         rows[r].base = 16'($random(seed));

      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (rst && cycles < READY_TIMEOUT);
      assert (!rst) else begin
         errors++;
         $display("reset was never released");
      end

      // idle state after reset
      host_access("done after reset", make_addr(REG_CTRL, 0, 0), 1'b0, '0, rd);
      check_value("done after reset", 16'h1, rd);
      host_write("conf write", make_addr(REG_CONF, 0, CONF_IDX_OP), 16'(OP_ADD));

      fill_memories(16'($random(seed)));
      verify_memories("readback");

      for (int r = 0; r < N_ROWS; r++) begin
         fill_memories(rows[r].base);
         for (int s = 0; s < `CGRA_N_STAGE; s++) begin
            host_write("conf op", make_addr(REG_CONF, s, CONF_IDX_OP), 16'(rows[r].op));
            host_write("conf src", make_addr(REG_CONF, s, CONF_IDX_SRC), 16'(rows[r].src));
            host_write("conf dst", make_addr(REG_CONF, s, CONF_IDX_DST), 16'(rows[r].dst));
            host_write("conf len", make_addr(REG_CONF, s, CONF_IDX_LEN), 16'(rows[r].len));
         end
         apply_row_to_model(rows[r]);
         run_and_wait($sformatf("row %0d", r), DONE_POLLS);
         verify_memories($sformatf("row %0d", r));
      end

      // cleared config means len 0, so the first poll already sees done
      host_write("global clear", make_addr(REG_CONF, 0, `CGRA_CONF_CLEAR), 16'h0);
      run_and_wait("cleared", 1);
      verify_memories("cleared");

      for (int s = 0; s < `CGRA_N_STAGE; s++) begin
         host_access("unmapped read", make_addr(REG_NONE, s, 3 * s + 1), 1'b0, '0, rd);
         check_value($sformatf("unmapped read s%0d", s), 16'h0, rd);
         for (int i = 0; i < 4; i++)
            host_write("unmapped write", make_addr(REG_NONE, s, i), 16'($random(seed)) | 16'h7);
      end
      run_and_wait("after unmapped", 1);
      verify_memories("after unmapped");

      total = errors + cgra_top_i.decoder_i.checker_i.fail_cnt;
      $display("checks %0d, check errors %0d, assertion failures %0d", checks, errors,
               cgra_top_i.decoder_i.checker_i.fail_cnt);
      if (total == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/cgra_addr_pkg.sv
src/cgra_fu_pkg.sv
src/cgra_ctrl_if.sv
src/cgra_addr_decoder.sv
src/cgra_conf_bank.sv
src/cgra_stage.sv
src/cgra_top.sv
verif/cgra_clkgen.sv
verif/cgra_checker.sv
verif/cgra_tb.sv
